// ==== common/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    typedef logic [31:0] inst_t;      // Raw instruction word
    typedef logic [31:0] addr_t;      // PC
    typedef logic [4:0]  areg_t;      // Architectural register x0..x31
    typedef logic [5:0]  preg_t;      // Physical register tag
    typedef logic [5:0]  rob_idx_t;   // ROB slot
    typedef logic [31:0] imm_t;       // Extended immediate
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  mem_size_t;  // Encoded like funct3[1:0]
    typedef logic [1:0]  fu_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_R_TYPE = 7'b0110011;  // ADD, XOR
    localparam logic [6:0] OP_I_TYPE = 7'b0010011;  // ADDI, ORI, SRAI
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // LB, LW
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // SB, SW
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_XOR  = 4'd1;
    localparam alu_op_t ALU_OR   = 4'd2;
    localparam alu_op_t ALU_SRA  = 4'd3;
    localparam alu_op_t ALU_PASS = 4'd4;   // Immediate straight through, for LUI

    localparam mem_size_t MEM_BYTE = 2'd0;
    localparam mem_size_t MEM_WORD = 2'd2;

    localparam fu_t FU_ALU0 = 2'd0;
    localparam fu_t FU_ALU1 = 2'd1;
    localparam fu_t FU_MEM  = 2'd2;

    // Storage depths
    localparam int NUM_AREGS = 32;
    localparam int NUM_PREGS = 64;
    localparam int ROB_DEPTH = 64;
    localparam int IQ_DEPTH  = 8;

endpackage

`default_nettype wire

// ==== design/frontend_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module frontend_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  logic                dec_legal,
    input  logic                dec_reg_write,
    input  frontend_pkg::areg_t dec_rd,
    input  logic                has_free,
    input  logic                iq_full,
    output logic                inst_ready,
    output logic                dec_load,
    output logic                dec_valid,
    output logic                advance,
    output logic                alloc_en
);

    logic needs_tag;   // Writes a real register, x0 excluded

    assign needs_tag = dec_reg_write && (dec_rd != '0);

    // Illegal entries still wait for queue room so that order is kept
    assign advance  = dec_valid && !iq_full && (has_free || !needs_tag);
    assign alloc_en = advance && needs_tag && dec_legal;

    assign inst_ready = !dec_valid || advance;   // Empty or emptying
    assign dec_load   = inst_valid && inst_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (dec_load) begin
            dec_valid <= 1'b1;    // Refill wins over drain
        end else if (advance) begin
            dec_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== decode/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dec_load,
    input  frontend_pkg::inst_t     inst,
    input  frontend_pkg::addr_t     inst_pc,
    output logic                    dec_legal,
    output frontend_pkg::addr_t     dec_pc,
    output logic [6:0]              dec_opcode,
    output frontend_pkg::areg_t     dec_rd,
    output frontend_pkg::areg_t     dec_rs1,
    output frontend_pkg::areg_t     dec_rs2,
    output frontend_pkg::imm_t      dec_imm,
    output logic                    dec_alu_src,    // 1 selects the immediate
    output logic                    dec_mem_read,
    output logic                    dec_mem_write,
    output logic                    dec_reg_write,
    output frontend_pkg::alu_op_t   dec_alu_op,
    output frontend_pkg::mem_size_t dec_mem_size
);
    import frontend_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_t       imm_i;
    mem_size_t  size;

    // Next values for the stage registers
    logic       n_legal;
    areg_t      n_rd;
    areg_t      n_rs1;
    areg_t      n_rs2;
    imm_t       n_imm;
    logic       n_alu_src;
    logic       n_mem_read;
    logic       n_mem_write;
    logic       n_reg_write;
    alu_op_t    n_alu_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign size   = (funct3 == 3'b000) ? MEM_BYTE : MEM_WORD;   // LB/SB vs LW/SW

    always_comb begin
        n_legal     = 1'b1;
        n_rd        = '0;     // Unused fields read as x0
        n_rs1       = '0;
        n_rs2       = '0;
        n_imm       = '0;
        n_alu_src   = 1'b0;
        n_mem_read  = 1'b0;
        n_mem_write = 1'b0;
        n_reg_write = 1'b0;
        n_alu_op    = ALU_ADD;
        case (opcode)
            OP_R_TYPE: begin
                n_rd        = inst[11:7];
                n_rs1       = inst[19:15];
                n_rs2       = inst[24:20];
                n_reg_write = 1'b1;
                if ({funct7, funct3} == 10'b0000000_100) begin
                    n_alu_op = ALU_XOR;
                end
            end
            OP_I_TYPE: begin
                n_rd        = inst[11:7];
                n_rs1       = inst[19:15];
                n_imm       = imm_i;
                n_alu_src   = 1'b1;
                n_reg_write = 1'b1;
                if (funct3 == 3'b110) begin
                    n_alu_op = ALU_OR;                        // ORI
                end else if (funct3 == 3'b101 && inst[31:26] == 6'b010000) begin
                    n_alu_op = ALU_SRA;                       // SRAI
                    n_imm    = {27'b0, inst[24:20]};          // shamt
                end
            end
            OP_LOAD: begin
                n_rd        = inst[11:7];
                n_rs1       = inst[19:15];
                n_imm       = imm_i;
                n_alu_src   = 1'b1;
                n_mem_read  = 1'b1;
                n_reg_write = 1'b1;
            end
            OP_STORE: begin
                n_rs1       = inst[19:15];
                n_rs2       = inst[24:20];
                n_imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};  // Split S-format
                n_alu_src   = 1'b1;
                n_mem_write = 1'b1;
            end
            OP_LUI: begin
                n_rd        = inst[11:7];
                n_imm       = {inst[31:12], 12'b0};
                n_alu_src   = 1'b1;
                n_reg_write = 1'b1;
                n_alu_op    = ALU_PASS;
            end
            default: n_legal = 1'b0;   // Dropped after stage 1
        endcase
    end

    // Fields that steer rename and stall logic
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_legal     <= 1'b0;
            dec_rd        <= '0;
            dec_rs1       <= '0;
            dec_rs2       <= '0;
            dec_mem_read  <= 1'b0;
            dec_mem_write <= 1'b0;
            dec_reg_write <= 1'b0;
        end else if (dec_load) begin
            dec_legal     <= n_legal;
            dec_rd        <= n_rd;
            dec_rs1       <= n_rs1;
            dec_rs2       <= n_rs2;
            dec_mem_read  <= n_mem_read;
            dec_mem_write <= n_mem_write;
            dec_reg_write <= n_reg_write;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (dec_load) begin
            dec_pc       <= inst_pc;
            dec_opcode   <= opcode;
            dec_imm      <= n_imm;
            dec_alu_src  <= n_alu_src;
            dec_alu_op   <= n_alu_op;
            dec_mem_size <= (n_mem_read || n_mem_write) ? size : MEM_WORD;
        end
    end

endmodule

`default_nettype wire

// ==== rename/rename_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_table (
    input  logic                clk,
    input  logic                rst_n,
    input  frontend_pkg::areg_t dec_rs1,
    input  frontend_pkg::areg_t dec_rs2,
    input  frontend_pkg::areg_t dec_rd,
    input  logic                alloc_en,
    output frontend_pkg::preg_t rs1_p,
    output frontend_pkg::preg_t rs2_p,
    output frontend_pkg::preg_t rd_p,
    output logic                has_free
);
    import frontend_pkg::*;

    preg_t                rat [NUM_AREGS];   // Alias table
    logic [NUM_PREGS-1:0] free_list;         // 1 = tag free
    preg_t                first_free;

    // Lowest free tag, the last hit of a downward scan wins
    always_comb begin
        first_free = '0;
        for (int i = NUM_PREGS - 1; i >= 0; i--) begin
            if (free_list[i]) begin
                first_free = preg_t'(i);
            end
        end
    end

    assign has_free = |free_list;

    assign rs1_p = (dec_rs1 == '0) ? '0 : rat[dec_rs1];   // x0 pinned to tag 0
    assign rs2_p = (dec_rs2 == '0) ? '0 : rat[dec_rs2];
    assign rd_p  = (dec_rd == '0) ? '0 : first_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_AREGS; k++) begin
                rat[k] <= preg_t'(k);        // Identity map
            end
            for (int k = 0; k < NUM_PREGS; k++) begin
                free_list[k] <= (k >= NUM_AREGS);   // Upper half free
            end
        end else if (alloc_en) begin
            rat[dec_rd]     <= rd_p;
            free_list[rd_p] <= 1'b0;   // Never returned, no retirement
        end
    end

endmodule

`default_nettype wire

// ==== rob/reorder_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc_en,
    input  frontend_pkg::preg_t    rd_p,
    input  frontend_pkg::preg_t    rs1_p,
    input  frontend_pkg::preg_t    rs2_p,
    output frontend_pkg::rob_idx_t head_idx,
    output logic                   src1_busy,
    output logic                   src2_busy
);
    import frontend_pkg::*;

    preg_t                rob_tag [ROB_DEPTH];   // Destination tag per slot
    logic [ROB_DEPTH-1:0] rob_used;              // Slot holds a tag
    logic                 hit1;
    logic                 hit2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_idx <= '0;
            rob_used <= '0;
        end else if (alloc_en) begin
            rob_used[head_idx] <= 1'b1;
            head_idx <= (head_idx == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : head_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rob_tag[head_idx] <= rd_p;
        end
    end

    // Associative search over every claimed slot
    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (rob_used[i] && rob_tag[i] == rs1_p) hit1 = 1'b1;
            if (rob_used[i] && rob_tag[i] == rs2_p) hit2 = 1'b1;
        end
    end

    assign src1_busy = hit1 && (rs1_p != '0);   // Tag 0 is always ready
    assign src2_busy = hit2 && (rs2_p != '0);

endmodule

`default_nettype wire

// ==== issue/issue_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    advance,
    input  logic                    dec_legal,
    input  frontend_pkg::addr_t     dec_pc,
    input  logic [6:0]              dec_opcode,
    input  frontend_pkg::imm_t      dec_imm,
    input  logic                    dec_alu_src,
    input  logic                    dec_mem_read,
    input  logic                    dec_mem_write,
    input  logic                    dec_reg_write,
    input  frontend_pkg::alu_op_t   dec_alu_op,
    input  frontend_pkg::mem_size_t dec_mem_size,
    input  frontend_pkg::preg_t     rd_p,
    input  frontend_pkg::preg_t     rs1_p,
    input  frontend_pkg::preg_t     rs2_p,
    input  logic                    src1_busy,
    input  logic                    src2_busy,
    input  frontend_pkg::rob_idx_t  head_idx,
    input  logic                    iss_ready,
    output logic                    iq_full,
    output logic                    iss_valid,
    output frontend_pkg::addr_t     iss_pc,
    output frontend_pkg::rob_idx_t  iss_rob_idx,
    output frontend_pkg::preg_t     iss_rd_p,
    output frontend_pkg::preg_t     iss_rs1_p,
    output frontend_pkg::preg_t     iss_rs2_p,
    output logic                    iss_rs1_ready,
    output logic                    iss_rs2_ready,
    output frontend_pkg::fu_t       iss_fu,
    output frontend_pkg::alu_op_t   iss_alu_op,
    output frontend_pkg::imm_t      iss_imm,
    output logic                    iss_alu_src,
    output logic                    iss_mem_read,
    output logic                    iss_mem_write,
    output logic                    iss_reg_write,
    output frontend_pkg::mem_size_t iss_mem_size
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(IQ_DEPTH);

    // Entry storage, one array per field
    addr_t     q_pc        [IQ_DEPTH];
    rob_idx_t  q_rob_idx   [IQ_DEPTH];
    preg_t     q_rd_p      [IQ_DEPTH];
    preg_t     q_rs1_p     [IQ_DEPTH];
    preg_t     q_rs2_p     [IQ_DEPTH];
    logic      q_rs1_ready [IQ_DEPTH];
    logic      q_rs2_ready [IQ_DEPTH];
    fu_t       q_fu        [IQ_DEPTH];
    alu_op_t   q_alu_op    [IQ_DEPTH];
    imm_t      q_imm       [IQ_DEPTH];
    logic      q_alu_src   [IQ_DEPTH];
    logic      q_mem_read  [IQ_DEPTH];
    logic      q_mem_write [IQ_DEPTH];
    logic      q_reg_write [IQ_DEPTH];
    mem_size_t q_mem_size  [IQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;     // Power-of-two depth, wraps on its own
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             alu_sel;    // Next ALU, 0 = ALU0
    logic             wr_en;
    logic             rd_en;
    logic             is_mem;
    fu_t              new_fu;

    assign wr_en  = advance && dec_legal;
    assign rd_en  = iss_valid && iss_ready;
    assign is_mem = (dec_opcode == OP_LOAD) || (dec_opcode == OP_STORE);
    assign new_fu = is_mem ? FU_MEM : (alu_sel ? FU_ALU1 : FU_ALU0);

    assign iq_full   = (count == IQ_DEPTH);
    assign iss_valid = (count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            alu_sel <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                         // Both or neither
            endcase
            if (wr_en && !is_mem) alu_sel <= !alu_sel;   // ALU0/ALU1 alternate
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            q_pc[wr_ptr]        <= dec_pc;
            q_rob_idx[wr_ptr]   <= head_idx;
            q_rd_p[wr_ptr]      <= rd_p;
            q_rs1_p[wr_ptr]     <= rs1_p;
            q_rs2_p[wr_ptr]     <= rs2_p;
            q_rs1_ready[wr_ptr] <= !src1_busy;
            q_rs2_ready[wr_ptr] <= !src2_busy;
            q_fu[wr_ptr]        <= new_fu;
            q_alu_op[wr_ptr]    <= dec_alu_op;
            q_imm[wr_ptr]       <= dec_imm;
            q_alu_src[wr_ptr]   <= dec_alu_src;
            q_mem_read[wr_ptr]  <= dec_mem_read;
            q_mem_write[wr_ptr] <= dec_mem_write;
            q_reg_write[wr_ptr] <= dec_reg_write;
            q_mem_size[wr_ptr]  <= dec_mem_size;
        end
    end

    // Oldest entry on the issue port
    assign iss_pc        = q_pc[rd_ptr];
    assign iss_rob_idx   = q_rob_idx[rd_ptr];
    assign iss_rd_p      = q_rd_p[rd_ptr];
    assign iss_rs1_p     = q_rs1_p[rd_ptr];
    assign iss_rs2_p     = q_rs2_p[rd_ptr];
    assign iss_rs1_ready = q_rs1_ready[rd_ptr];
    assign iss_rs2_ready = q_rs2_ready[rd_ptr];
    assign iss_fu        = q_fu[rd_ptr];
    assign iss_alu_op    = q_alu_op[rd_ptr];
    assign iss_imm       = q_imm[rd_ptr];
    assign iss_alu_src   = q_alu_src[rd_ptr];
    assign iss_mem_read  = q_mem_read[rd_ptr];
    assign iss_mem_write = q_mem_write[rd_ptr];
    assign iss_reg_write = q_reg_write[rd_ptr];
    assign iss_mem_size  = q_mem_size[rd_ptr];

endmodule

`default_nettype wire

// ==== design/frontend_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module frontend_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // Instruction input
    input  logic                    inst_valid,
    input  frontend_pkg::inst_t     inst,
    input  frontend_pkg::addr_t     inst_pc,
    output logic                    inst_ready,
    // Issue port
    output logic                    iss_valid,
    output frontend_pkg::addr_t     iss_pc,
    output frontend_pkg::rob_idx_t  iss_rob_idx,
    output frontend_pkg::preg_t     iss_rd_p,
    output frontend_pkg::preg_t     iss_rs1_p,
    output frontend_pkg::preg_t     iss_rs2_p,
    output logic                    iss_rs1_ready,
    output logic                    iss_rs2_ready,
    output frontend_pkg::fu_t       iss_fu,
    output frontend_pkg::alu_op_t   iss_alu_op,
    output frontend_pkg::imm_t      iss_imm,
    output logic                    iss_alu_src,
    output logic                    iss_mem_read,
    output logic                    iss_mem_write,
    output logic                    iss_reg_write,
    output frontend_pkg::mem_size_t iss_mem_size,
    input  logic                    iss_ready
);
    import frontend_pkg::*;

    // Stage control
    logic       dec_load;
    logic       advance;
    logic       alloc_en;

    // Stage-1 registers
    logic       dec_legal;
    addr_t      dec_pc;
    logic [6:0] dec_opcode;
    areg_t      dec_rd;
    areg_t      dec_rs1;
    areg_t      dec_rs2;
    imm_t       dec_imm;
    logic       dec_alu_src;
    logic       dec_mem_read;
    logic       dec_mem_write;
    logic       dec_reg_write;
    alu_op_t    dec_alu_op;
    mem_size_t  dec_mem_size;

    // Rename and ROB lookups, all combinational from stage 1
    preg_t      rs1_p;
    preg_t      rs2_p;
    preg_t      rd_p;
    logic       has_free;
    rob_idx_t   head_idx;
    logic       src1_busy;
    logic       src2_busy;
    logic       iq_full;

    frontend_ctrl u_ctrl (
        .*,
        .dec_valid ()       // Only used inside the controller
    );

    inst_decoder u_decoder (.*);

    rename_table u_rename (.*);

    reorder_buffer u_rob (.*);

    issue_queue u_iq (.*);

endmodule

`default_nettype wire

// ==== sim/frontend_tb_tasks.svh ====
`ifndef FRONTEND_TB_TASKS_SVH
`define FRONTEND_TB_TASKS_SVH

// Expected issue-port contents, one per kept instruction
typedef struct packed {
    addr_t     pc;
    rob_idx_t  rob_idx;
    preg_t     rd_p;
    preg_t     rs1_p;
    preg_t     rs2_p;
    logic      rs1_ready;
    logic      rs2_ready;
    fu_t       fu;
    alu_op_t   alu_op;
    imm_t      imm;
    logic      alu_src;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    mem_size_t mem_size;
} issue_t;

issue_t exp_q[$];

// Reference rename state
preg_t alias_map [NUM_AREGS];
logic  renamed   [NUM_AREGS];   // Written since reset
int    next_tag;
int    alloc_count;
logic  alu_toggle;
logic  blocked;                 // Out of tags, nothing more issues
addr_t pc_next;

// Kind 0..9 is ADD XOR ADDI ORI SRAI LB LW SB SW LUI
function automatic inst_t build_inst(input int kind, input areg_t rd, input areg_t rs1,
                                     input areg_t rs2, input logic [11:0] imm);
    case (kind)
        0: return {7'd0, rs2, rs1, 3'd0, rd, OP_R_TYPE};
        1: return {7'd0, rs2, rs1, 3'd4, rd, OP_R_TYPE};
        2: return {imm, rs1, 3'd0, rd, OP_I_TYPE};
        3: return {imm, rs1, 3'd6, rd, OP_I_TYPE};
        4: return {7'b0100000, imm[4:0], rs1, 3'd5, rd, OP_I_TYPE};
        5: return {imm, rs1, 3'd0, rd, OP_LOAD};
        6: return {imm, rs1, 3'd2, rd, OP_LOAD};
        7: return {imm[11:5], rs2, rs1, 3'd0, imm[4:0], OP_STORE};
        8: return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], OP_STORE};
        default: return {imm, rs1, 3'b101, rd, OP_LUI};   // 20-bit upper field
    endcase
endfunction

// Registers x0..x7 only, so dependencies are common
function automatic inst_t rand_inst(input logic writes_only);
    int    kind;
    areg_t rd;
    kind = int'(lfsr_bits(4) % 10);
    rd   = areg_t'(lfsr_bits(3));
    if (writes_only && (kind == 7 || kind == 8)) kind = 6;
    if (writes_only && rd == '0) rd = 5'd1;
    return build_inst(kind, rd, areg_t'(lfsr_bits(3)), areg_t'(lfsr_bits(3)),
                      12'(lfsr_bits(12)));
endfunction

task automatic model_accept(input inst_t w, input addr_t pc);
    issue_t     e;
    areg_t      rd;
    areg_t      rs1;
    areg_t      rs2;
    logic       legal;
    logic [2:0] f3;
    f3    = w[14:12];
    legal = 1'b1;
    rd    = w[11:7];
    rs1   = w[19:15];
    rs2   = w[24:20];
    e          = '0;
    e.pc       = pc;
    e.alu_op   = ALU_ADD;    // Fallback for odd funct values
    e.mem_size = MEM_WORD;
    e.alu_src  = 1'b1;
    e.imm      = {{20{w[31]}}, w[31:20]};
    case (w[6:0])
        OP_R_TYPE: begin
            e.alu_src   = 1'b0;
            e.imm       = '0;
            e.reg_write = 1'b1;
            if (w[31:25] == 7'd0 && f3 == 3'd4) e.alu_op = ALU_XOR;
        end
        OP_I_TYPE: begin
            rs2         = '0;
            e.reg_write = 1'b1;
            if (f3 == 3'd6) e.alu_op = ALU_OR;
            if (f3 == 3'd5 && w[31:26] == 6'b010000) begin
                e.alu_op = ALU_SRA;
                e.imm    = {27'd0, w[24:20]};   // Shift amount
            end
        end
        OP_LOAD: begin
            rs2         = '0;
            e.reg_write = 1'b1;
            e.mem_read  = 1'b1;
            e.mem_size  = (f3 == 3'd0) ? MEM_BYTE : MEM_WORD;
        end
        OP_STORE: begin
            rd          = '0;
            e.imm       = {{20{w[31]}}, w[31:25], w[11:7]};
            e.mem_write = 1'b1;
            e.mem_size  = (f3 == 3'd0) ? MEM_BYTE : MEM_WORD;
        end
        OP_LUI: begin
            rs1         = '0;
            rs2         = '0;
            e.imm       = {w[31:12], 12'd0};
            e.alu_op    = ALU_PASS;
            e.reg_write = 1'b1;
        end
        default: legal = 1'b0;   // Consumed, never issued
    endcase
    if (blocked || !legal) return;
    e.rs1_p     = (rs1 == '0) ? '0 : alias_map[rs1];   // Sources before own rename
    e.rs2_p     = (rs2 == '0) ? '0 : alias_map[rs2];
    e.rs1_ready = (rs1 == '0) || !renamed[rs1];
    e.rs2_ready = (rs2 == '0) || !renamed[rs2];
    e.rob_idx   = rob_idx_t'(alloc_count);
    if (e.reg_write && rd != '0) begin
        if (next_tag == NUM_PREGS) begin
            blocked = 1'b1;   // Waits for a tag that never comes back
            return;
        end
        e.rd_p        = preg_t'(next_tag);
        alias_map[rd] = preg_t'(next_tag);
        renamed[rd]   = 1'b1;
        next_tag++;
        alloc_count++;
    end
    if (e.mem_read || e.mem_write) begin
        e.fu = FU_MEM;
    end else begin
        e.fu       = alu_toggle ? FU_ALU1 : FU_ALU0;
        alu_toggle = !alu_toggle;
    end
    exp_q.push_back(e);
endtask

task automatic compare_issue();
    issue_t e;
    e = exp_q.pop_front();
    check_value("iss_pc", iss_pc, e.pc);
    check_value("iss_rob_idx", iss_rob_idx, e.rob_idx);
    check_value("iss_rd_p", iss_rd_p, e.rd_p);
    check_value("iss_rs1_p", iss_rs1_p, e.rs1_p);
    check_value("iss_rs2_p", iss_rs2_p, e.rs2_p);
    check_value("iss_rs1_ready", iss_rs1_ready, e.rs1_ready);
    check_value("iss_rs2_ready", iss_rs2_ready, e.rs2_ready);
    check_value("iss_fu", iss_fu, e.fu);
    check_value("iss_alu_op", iss_alu_op, e.alu_op);
    check_value("iss_imm", iss_imm, e.imm);
    check_value("iss_alu_src", iss_alu_src, e.alu_src);
    check_value("iss_mem_read", iss_mem_read, e.mem_read);
    check_value("iss_mem_write", iss_mem_write, e.mem_write);
    check_value("iss_reg_write", iss_reg_write, e.reg_write);
    check_value("iss_mem_size", iss_mem_size, e.mem_size);
endtask

task automatic apply_reset();
    @(posedge clk);
    rst_n      <= 1'b0;
    inst_valid <= 1'b0;
    iss_ready  <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int k = 0; k < NUM_AREGS; k++) begin
        alias_map[k] = preg_t'(k);   // Identity map, as in hardware
        renamed[k]   = 1'b0;
    end
    next_tag    = NUM_AREGS;
    alloc_count = 0;
    alu_toggle  = 1'b0;
    blocked     = 1'b0;
    pc_next     = 32'h0000_1000;
    exp_q.delete();
    @(negedge clk);
    check_value("inst_ready", inst_ready, 1'b1);
    check_value("iss_valid", iss_valid, 1'b0);
endtask

task automatic hold_ready(input logic level);
    @(posedge clk);
    iss_ready <= level;
endtask

// Holds the word until taken or until the limit runs out
task automatic send_inst(input inst_t word, input int limit, output logic accepted);
    int cycles;
    cycles = 0;
    @(posedge clk);
    inst_valid <= 1'b1;
    inst       <= word;
    inst_pc    <= pc_next;
    @(negedge clk);
    while (!inst_ready && cycles < limit) begin
        @(negedge clk);
        cycles++;
    end
    accepted = inst_ready;
    @(posedge clk);   // Transfer edge when taken
    inst_valid <= 1'b0;
    if (accepted) model_accept(word, pc_next);
    pc_next += 4;
endtask

task automatic send(input inst_t word);
    logic accepted;
    send_inst(word, TIMEOUT, accepted);
    if (!accepted) begin
        timeouts++;
        $display("Timeout: instruction %h was never accepted", word);
    end
endtask

task automatic wait_issued(input logic random_gaps);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (exp_q.size() != 0 && cycles < TIMEOUT) begin
        iss_ready <= random_gaps ? (lfsr_bits(1) != 0) : 1'b1;
        @(posedge clk);
        cycles++;
    end
    iss_ready <= 1'b1;
    if (exp_q.size() != 0) begin
        timeouts++;
        $display("Timeout: %0d instructions never left the issue queue", exp_q.size());
    end
endtask

`endif

// ==== sim/frontend_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module frontend_tb;
    import frontend_pkg::*;

    localparam int TIMEOUT = 200;   // Cycles allowed per wait loop

    logic      clk = 1'b0;
    logic      rst_n;
    logic      inst_valid;
    inst_t     inst;
    addr_t     inst_pc;
    logic      inst_ready;
    logic      iss_valid;
    addr_t     iss_pc;
    rob_idx_t  iss_rob_idx;
    preg_t     iss_rd_p;
    preg_t     iss_rs1_p;
    preg_t     iss_rs2_p;
    logic      iss_rs1_ready;
    logic      iss_rs2_ready;
    fu_t       iss_fu;
    alu_op_t   iss_alu_op;
    imm_t      iss_imm;
    logic      iss_alu_src;
    logic      iss_mem_read;
    logic      iss_mem_write;
    logic      iss_reg_write;
    mem_size_t iss_mem_size;
    logic      iss_ready;

    logic [31:0] lfsr;
    int          errors = 0;
    int          timeouts = 0;
    int          issued = 0;   // Entries taken off the issue port

    frontend_top UUT (.*);

    always #50 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};   // One step per bit
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    `include "frontend_tb_tasks.svh"

    // Transfer seen half a cycle ahead of its edge
    always @(negedge clk) begin
        if (rst_n && iss_valid && iss_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected issue of an entry with pc %h", iss_pc);
            end else begin
                compare_issue();
                issued++;
            end
        end
    end

    task automatic test_decode();
        hold_ready(1'b1);
        send(build_inst(0, 5'd1, 5'd2, 5'd3, 12'h000));    // ADD
        send(build_inst(1, 5'd4, 5'd1, 5'd5, 12'h000));    // XOR, x1 renamed
        send(build_inst(2, 5'd6, 5'd4, 5'd0, 12'hf9c));    // ADDI, negative
        send(build_inst(3, 5'd7, 5'd6, 5'd0, 12'h8a5));    // ORI
        send(build_inst(4, 5'd8, 5'd7, 5'd0, 12'h01f));    // SRAI by 31
        send(build_inst(5, 5'd9, 5'd8, 5'd0, 12'h804));    // LB
        send(build_inst(6, 5'd10, 5'd9, 5'd0, 12'h7fc));   // LW
        send(build_inst(7, 5'd0, 5'd10, 5'd1, 12'hfff));   // SB
        send(build_inst(8, 5'd0, 5'd2, 5'd10, 12'h123));   // SW
        send(build_inst(9, 5'd11, 5'd31, 5'd0, 12'habc));  // LUI
        wait_issued(1'b0);
    endtask

    task automatic test_rename();
        hold_ready(1'b1);
        send(build_inst(2, 5'd5, 5'd0, 5'd0, 12'h001));
        send(build_inst(0, 5'd6, 5'd5, 5'd7, 12'h000));   // Reads new x5, old x7
        send(build_inst(2, 5'd0, 5'd5, 5'd0, 12'h003));   // x0 target, no tag
        send(build_inst(2, 5'd5, 5'd5, 5'd0, 12'h002));   // Reads and renames x5
        send(build_inst(6, 5'd8, 5'd5, 5'd0, 12'h004));
        send(build_inst(8, 5'd0, 5'd8, 5'd6, 12'h000));
        repeat (16) send(rand_inst(1'b0));
        wait_issued(1'b1);
    endtask

    task automatic test_order();
        hold_ready(1'b0);   // Let the queue collect first
        send(build_inst(0, 5'd1, 5'd2, 5'd3, 12'h000));
        send(build_inst(6, 5'd2, 5'd1, 5'd0, 12'h010));
        send(32'h0000_80ff);                               // Unknown opcode
        send(build_inst(2, 5'd3, 5'd2, 5'd0, 12'h7ff));
        send(build_inst(8, 5'd0, 5'd3, 5'd1, 12'h020));
        send(build_inst(9, 5'd4, 5'd0, 5'd0, 12'h123));
        send(32'h0020_8463);                               // Branch, not kept
        send(build_inst(1, 5'd5, 5'd4, 5'd3, 12'h000));
        send(build_inst(3, 5'd6, 5'd5, 5'd0, 12'h0f0));
        wait_issued(1'b1);
    endtask

    task automatic test_backpressure();
        logic accepted;
        int   n;
        n = 0;
        hold_ready(1'b0);
        for (int i = 0; i < IQ_DEPTH + 4; i++) begin
            send_inst(rand_inst(1'b0), 20, accepted);
            if (!accepted) break;
            n++;
        end
        @(negedge clk);
        check_value("accepted count", n, IQ_DEPTH + 1);   // Queue plus stage 1
        check_value("inst_ready", inst_ready, 1'b0);
        wait_issued(1'b1);
    endtask

    task automatic test_exhaust();
        logic accepted;
        hold_ready(1'b1);
        repeat (32) send(rand_inst(1'b1));
        send(build_inst(8, 5'd0, 5'd1, 5'd2, 12'h010));   // Store, needs no tag
        send(rand_inst(1'b1));                            // Parks in stage 1
        wait_issued(1'b0);
        send_inst(rand_inst(1'b0), TIMEOUT, accepted);
        if (accepted) begin
            errors++;
            $display("Instruction behind the stalled rename was accepted");
        end
        @(negedge clk);
        check_value("iss_valid", iss_valid, 1'b0);
    endtask

    initial begin
        rst_n      <= 1'b0;
        inst_valid <= 1'b0;
        inst       <= '0;
        inst_pc    <= '0;
        iss_ready  <= 1'b0;
        lfsr = 32'h7961_b796;
        apply_reset();
        test_decode();
        apply_reset();
        test_rename();
        apply_reset();
        test_order();
        apply_reset();
        test_backpressure();
        apply_reset();
        test_exhaust();
        $display("Summary: %0d errors, %0d timeouts, %0d entries issued",
                 errors, timeouts, issued);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+sim
common/frontend_pkg.sv
design/frontend_ctrl.sv
decode/inst_decoder.sv
rename/rename_table.sv
rob/reorder_buffer.sv
issue/issue_queue.sv
design/frontend_top.sv
sim/frontend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= frontend_tb
LINT_TOP  ?= frontend_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation did not finish"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
